//--- rtl/montPkg.sv
package montPkg;

    // operand width in bits, every type below is sized from it
    localparam int WIDTH = 512;

    // one operand or result word
    typedef logic [WIDTH-1:0] wordT;

    // running sum
    // two spare bits so sum + b + m (below 4M) fits before halving
    typedef logic [WIDTH+1:0] accT;

    // the three operands travel together
    // a is shifted down a digit per step, b and m hold still
    typedef struct packed {
        wordT a;
        wordT b;
        wordT m;
    } operandsT;

    // one-hot (or idle) command from the sequencer
    typedef struct packed {
        // clear sum, capture operands
        logic load;
        // consume one digit of a
        logic step;
        // final conditional subtraction
        logic reduce;
    } stepCtrlT;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        LOOP,
        REDUCE,
        DONE
    } stateT;

endpackage

//--- rtl/montOperands.sv
`timescale 1ns/1ps

module montOperands #(
    parameter int DIGIT_BITS = 4
) (
    input  logic              clk,
    input  logic              resetn,
    input  montPkg::stepCtrlT ctrl,
    input  montPkg::operandsT opsIn,
    output montPkg::operandsT ops
);

    // shift distance for a, one digit per step
    localparam int SHIFT = DIGIT_BITS;

    montPkg::wordT aShifted;

    // zero fill from the top
    // the current digit always sits in the low bits
    assign aShifted = ops.a >> SHIFT;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            ops <= '0;
        end
        else if (ctrl.load)
        begin
            // all three fields latched together
            ops <= opsIn;
        end
        else if (ctrl.step)
        begin
            // b and m stay put for the whole run
            ops.a <= aShifted;
        end
    end

    // reduce needs nothing from here
    // registers just hold their values

endmodule

//--- rtl/montControl.sv
`timescale 1ns/1ps

module montControl #(
    parameter int DIGIT_BITS = 4
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    output montPkg::stepCtrlT ctrl,
    output logic              done
);

    localparam int NUM_DIGITS = montPkg::WIDTH / DIGIT_BITS;
    localparam int CNT_BITS = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;

    montPkg::stateT      state;
    montPkg::stateT      nextState;
    logic [CNT_BITS-1:0] digitCount;
    logic                accept;
    logic                lastDigit;

    // start only counts when no run is in flight
    assign accept = start && (state == montPkg::IDLE || state == montPkg::DONE);
    assign lastDigit = (digitCount == CNT_BITS'(NUM_DIGITS - 1));

    // next state
    always_comb
    begin
        nextState = montPkg::IDLE;
        case (state)
            montPkg::IDLE, montPkg::DONE:
            begin
                // back to idle unless a new run starts straight away
                nextState = accept ? montPkg::LOAD : montPkg::IDLE;
            end
            montPkg::LOAD:   nextState = montPkg::LOOP;
            montPkg::LOOP:   nextState = lastDigit ? montPkg::REDUCE : montPkg::LOOP;
            montPkg::REDUCE: nextState = montPkg::DONE;
            default:         nextState = montPkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            state <= montPkg::IDLE;
        else
            state <= nextState;
    end

    // digit counter, cleared with the operand capture
    always_ff @(posedge clk)
    begin
        if (!resetn || ctrl.load)
            digitCount <= '0;
        else if (ctrl.step)
            digitCount <= digitCount + 1'b1;
    end

    // load rides on the accepted start, so the inputs are taken in that cycle
    assign ctrl.load   = accept;
    assign ctrl.step   = (state == montPkg::LOOP);
    assign ctrl.reduce = (state == montPkg::REDUCE);

    // result register was written on the edge into DONE
    assign done = (state == montPkg::DONE);

endmodule

//--- rtl/montAccumulate.sv
`timescale 1ns/1ps

module montAccumulate #(
    parameter int DIGIT_BITS = 4
) (
    input  logic              clk,
    input  logic              resetn,
    input  montPkg::stepCtrlT ctrl,
    input  montPkg::operandsT ops,
    output montPkg::accT      sum
);

    logic [DIGIT_BITS-1:0] digit;
    montPkg::accT          bExt;
    montPkg::accT          mExt;
    montPkg::accT          nextSum;

    // current digit of a, lsb first
    assign digit = ops.a[DIGIT_BITS-1:0];

    // zero extend into the sum width
    assign bExt = montPkg::accT'(ops.b);
    assign mExt = montPkg::accT'(ops.m);

    // DIGIT_BITS radix-2 steps chained in one cycle
    // per bit: add b if set, add m if odd, halve
    // parity of the partial sum is the quotient bit, m odd makes it even
    always_comb
    begin
        montPkg::accT partial;
        partial = sum;
        for (int i = 0; i < DIGIT_BITS; i++)
        begin
            if (digit[i])
                partial = partial + bExt;
            // quotient bit
            if (partial[0])
                partial = partial + mExt;
            // exact division by two, low bit is zero here
            partial = partial >> 1;
        end
        nextSum = partial;
    end

    // sum < 2M holds after every step
    // (s + b + m) / 2 < (2M + M + M) / 2
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            sum <= '0;
        end
        else if (ctrl.load)
        begin
            // fresh run
            sum <= '0;
        end
        else if (ctrl.step)
        begin
            sum <= nextSum;
        end
    end

    // sum is held through reduce and done
    // montReduce reads it during the reduce cycle

endmodule

//--- rtl/montReduce.sv
`timescale 1ns/1ps

module montReduce (
    input  logic              clk,
    input  logic              resetn,
    input  montPkg::stepCtrlT ctrl,
    input  montPkg::accT      sum,
    input  montPkg::wordT     m,
    output montPkg::wordT     result
);

    // one extra bit over the sum so the top bit is the borrow
    logic [montPkg::WIDTH+2:0] diff;
    logic                      noBorrow;

    // sum - m, both zero extended
    assign diff = {1'b0, sum} - {3'b000, m};

    // no borrow means sum >= m
    assign noBorrow = !diff[montPkg::WIDTH+2];

    // sum < 2M so one subtraction is enough
    // either choice then fits in a word
    always_ff @(posedge clk)
    begin
        if (!resetn)
            result <= '0;
        else if (ctrl.reduce)
            result <= noBorrow ? diff[montPkg::WIDTH-1:0] : sum[montPkg::WIDTH-1:0];
    end

    // result holds until the next reduce cycle

endmodule

//--- rtl/montgomery.sv
`timescale 1ns/1ps

module montgomery #(
    parameter int DIGIT_BITS = 4
) (
    input  logic          clk,
    input  logic          resetn,
    input  logic          start,
    input  montPkg::wordT inA,
    input  montPkg::wordT inB,
    input  montPkg::wordT inM,
    output montPkg::wordT result,
    output logic          done
);

    montPkg::stepCtrlT ctrl;
    montPkg::operandsT opsIn;
    montPkg::operandsT ops;
    montPkg::accT      sum;

    // inputs bundled for the operand registers
    assign opsIn = '{a: inA, b: inB, m: inM};

    // sequencer, load/step/reduce and done
    montControl #(.DIGIT_BITS(DIGIT_BITS)) iControl (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .ctrl   (ctrl),
        .done   (done)
    );

    // latched a, b, m with a shifting down per digit
    montOperands #(.DIGIT_BITS(DIGIT_BITS)) iOperands (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .opsIn  (opsIn),
        .ops    (ops)
    );

    // running sum
    montAccumulate #(.DIGIT_BITS(DIGIT_BITS)) iAccumulate (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .ops    (ops),
        .sum    (sum)
    );

    // final subtraction uses the latched m, not the live input
    montReduce iReduce (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (ctrl),
        .sum    (sum),
        .m      (ops.m),
        .result (result)
    );

endmodule

//--- test/montgomery_assert.sv
`timescale 1ns/1ps

module montgomery_assert #(
    parameter int DIGIT_BITS = 4
) (
    input logic          clk,
    input logic          resetn,
    input logic          accepted,
    input logic          done,
    input montPkg::wordT result,
    input montPkg::wordT m
);

    localparam int LATENCY = montPkg::WIDTH / DIGIT_BITS + 2;

    // done is a one-cycle strobe
    doneOneCycle: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // accept cycle sits LATENCY + 1 samples before the done cycle
    doneAfterStart: assert property (@(posedge clk) disable iff (!resetn)
        done |-> $past(accepted, LATENCY + 1))
        else $error("done without an accepted start %0d cycles earlier", LATENCY);

    // fully reduced against the latched modulus
    resultBelowM: assert property (@(posedge clk) disable iff (!resetn) done |-> result < m)
        else $error("result not below the latched modulus while done is high");

endmodule

//--- test/montgomery_tb.sv
`timescale 1ns/1ps

module montgomery_tb;

    localparam int DIGIT_BITS = 4;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_VECTORS = 6;
    // accepting edge to done, load + digits + reduce
    localparam int LATENCY = montPkg::WIDTH / DIGIT_BITS + 2;
    localparam int MAX_GAP = 8;
    // this run gets a second start while busy
    localparam int MID_RUN_VECTOR = 2;
    localparam int MID_RUN_CYCLE = 40;
    localparam int WATCHDOG_NS = (NUM_VECTORS + 2) * (LATENCY + MAX_GAP) * CLK_PERIOD;

    logic          clk;
    logic          resetn;
    logic          start;
    montPkg::wordT inA;
    montPkg::wordT inB;
    montPkg::wordT inM;
    montPkg::wordT result;
    logic          done;

    // four words per record: a, b, m, expected
    montPkg::wordT vecMem [0:4*NUM_VECTORS-1];
    montPkg::wordT prevResult;
    int            seed;
    int            gap;
    int            mismatchCount;
    int            failCount;

    montgomery #(.DIGIT_BITS(DIGIT_BITS)) i_montgomery (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .inA    (inA),
        .inB    (inB),
        .inM    (inM),
        .result (result),
        .done   (done)
    );

    // handshake and range checks inside the DUT
    bind montgomery montgomery_assert #(.DIGIT_BITS(DIGIT_BITS)) i_assert (
        .clk      (clk),
        .resetn   (resetn),
        .accepted (ctrl.load),
        .done     (done),
        .result   (result),
        .m        (ops.m)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // junk operands, only used where the DUT must ignore them
    function automatic montPkg::wordT randomWord();
        montPkg::wordT w;
        w = '0;
        for (int i = 0; i < montPkg::WIDTH / 32; i++)
            w[32*i +: 32] = $random(seed);
        return w;
    endfunction

    task automatic checkResult(input montPkg::wordT got, input montPkg::wordT expected,
                               input string what);
        if (got !== expected)
        begin
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, expected);
            mismatchCount++;
        end
    endtask

    task automatic checkDone(input int latency, input int pulses, input int idx);
        if (pulses == 0)
        begin
            $display("Vector %0d never saw done within %0d cycles", idx, LATENCY + 4);
            failCount++;
        end
        else if (latency != LATENCY || pulses != 1)
        begin
            $display("Mismatch at %0t ns: vector %0d done after %0d cycles, %0d pulses",
                     $time, idx, latency, pulses);
            mismatchCount++;
        end
    endtask

    task automatic runVector(input int idx, input bit midRun);
        montPkg::wordT expected;
        int cycles;
        int latency;
        int pulses;
        expected = vecMem[4*idx+3];
        inA = vecMem[4*idx];
        inB = vecMem[4*idx+1];
        inM = vecMem[4*idx+2];
        start = 1'b1;
        // next rising edge accepts the run
        @(negedge clk);
        start = 1'b0;
        // operands are latched, the run must not see these
        inA = randomWord();
        inB = randomWord();
        inM = randomWord();
        cycles = 0;
        latency = 0;
        pulses = 0;
        while (latency == 0 && cycles < LATENCY + 4)
        begin
            // start while busy, ignored by the sequencer
            start = midRun && (cycles == MID_RUN_CYCLE);
            @(negedge clk);
            cycles++;
            if (done)
                latency = cycles;
            else
                checkResult(result, prevResult, "old result held during run");
        end
        start = 1'b0;
        if (latency != 0)
        begin
            pulses = 1;
            checkResult(result, expected, $sformatf("product of vector %0d", idx));
            // done must drop after one cycle and stay low
            repeat (3)
            begin
                @(negedge clk);
                if (done)
                    pulses++;
                checkResult(result, expected, "result held after done");
            end
        end
        checkDone(latency, pulses, idx);
        prevResult = expected;
    endtask

    initial
    begin
        seed = 32'he85f_82b9;
        mismatchCount = 0;
        failCount = 0;
        prevResult = '0;
        resetn = 1'b0;
        start = 1'b0;
        inA = '0;
        inB = '0;
        inM = '0;
        $readmemh("test/montgomery_vectors.hex", vecMem);
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            // idle gap, first one also covers the post-reset state
            gap = {$random(seed)} % (MAX_GAP + 1);
            repeat (gap)
            begin
                if (done)
                begin
                    $display("done was high while the unit was idle");
                    failCount++;
                end
                checkResult(result, prevResult, "result held while idle");
                @(negedge clk);
            end
            runVector(i, i == MID_RUN_VECTOR);
        end
        $display("Error counts: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // upper bound from the run lengths, with two runs of slack
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- test/montgomery_vectors.hex
// one record per four lines: A, B, M, expected A*B*2^-512 mod M
// 512-bit words in hex, shorter words are zero extended
1
9f3a61c07e4b2d58a1e7304cf96b825d4c0e93b7a2f6581de3779b97f4a7c15f27d4eb2f165667c50b8f3e61d2a4c9756a09e667f3bcc908bb67ae8584caa73b
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
9f3a61c07e4b2d58a1e7304cf96b825d4c0e93b7a2f6581de3779b97f4a7c15f27d4eb2f165667c50b8f3e61d2a4c9756a09e667f3bcc908bb67ae8584caa73b
fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe
3c6ef372fe94f82ba54ff53a5f1d36f1510e527fade682d19b05688c2b3e6c1f1f83d9abfb41bd6b5be0cd19137e2179c1059ed8367cd5073070dd17f70e5939
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
c3910c8d016b07d45ab00ac5a0e2c90eaef1ad8052197d2e64fa9773d4c193e0e07c265404be4294a41f32e6ec81de863efa6127c9832af8cf8f22e808f1a6c6
10000000000000000
428a2f98d728ae227137449123ef65cdb5c0fbcfec4d3b2fe9b5dba58189dbbc3956c25bf348b53859f111f1b605d019923f82a4af194f9bab1c5ed5da6d8118
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
7137449123ef65cdb5c0fbcfec4d3b2fe9b5dba58189dbbc3956c25bf348b53859f111f1b605d019923f82a4af194f9bab1c5ed5da6d8118428a2f98d728ae22
100
300
10001
fffe
1234
abcd
ffffffff
c374fa4
0
5
7
0

//--- montgomery.f
rtl/montPkg.sv
rtl/montOperands.sv
rtl/montControl.sv
rtl/montAccumulate.sv
rtl/montReduce.sv
rtl/montgomery.sv
test/montgomery_assert.sv
test/montgomery_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= montgomery_tb
RTL_TOP   ?= montgomery
FILELIST  ?= montgomery.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# output goes to the terminal, status comes from the search for the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
